// ==== act_ctrl/act_sp_ctrl.sv ====
`timescale 1ns/1ns

module act_sp_ctrl
(
	input  logic                                         arst_n_i,
	// Index two clocks late, when feed-forward results reach the memories
	input  logic [nn_ctrl_pkg::CI_W-1:0]              ci_d2_i,
	input  logic [nn_ctrl_pkg::PTR_W-1:0]             w_pt_i,
	// Z memory indices from the interleaver, bank 0 in the low bits
	input  logic [nn_ctrl_pkg::Z*nn_ctrl_pkg::IDX_W-1:0] mem_index_i,
	// One address per bank, collection 0 in the low bits
	output logic [nn_ctrl_pkg::COLL*nn_ctrl_pkg::Z*nn_ctrl_pkg::CELL_W-1:0] act_addr_o,
	output logic [nn_ctrl_pkg::COLL*nn_ctrl_pkg::Z-1:0]                     act_we_o,
	// Cell fields of the indices, shared with the delta memories
	output logic [nn_ctrl_pkg::Z*nn_ctrl_pkg::CELL_W-1:0]                   rd_addr_o
);

	// Cell that the current part writes into, the same for all its banks
	logic [nn_ctrl_pkg::CELL_W-1:0]        wr_cell;

	// Part whose banks take data in this clock
	logic [$clog2(nn_ctrl_pkg::FO)-1:0]    wr_part;

	// High while feed-forward results are still arriving
	logic                                  wr_window;

	// Each part is visited once per cell, so the cell is the index with the
	// part bits dropped
	assign wr_cell = ci_d2_i[nn_ctrl_pkg::CELL_W + $clog2(nn_ctrl_pkg::FO) - 1
		-: nn_ctrl_pkg::CELL_W];

	assign wr_part = ci_d2_i[$clog2(nn_ctrl_pkg::FO)-1:0]; // Parts take turns clock by clock

	// The last two index values are the pipeline slack and write nothing
	assign wr_window = arst_n_i && (ci_d2_i < nn_ctrl_pkg::ACTIVE_CLKS);

	// Read address of each bank
	for (genvar b = 0; b < nn_ctrl_pkg::Z; b++)
	begin : g_rd_addr
		// Only the cell field addresses a bank
		// The bank field picks a bank, and that selection sits at the memories
		assign rd_addr_o[b*nn_ctrl_pkg::CELL_W +: nn_ctrl_pkg::CELL_W] =
			mem_index_i[(b+1)*nn_ctrl_pkg::IDX_W-1 -: nn_ctrl_pkg::CELL_W];
	end

	// Sigmoid-prime memories are wired to the same addresses and enables,
	// so one set of controls covers both memory types
	for (genvar c = 0; c < nn_ctrl_pkg::COLL; c++)
	begin : g_coll
		logic wr_sel; // This collection is the one being filled

		assign wr_sel = (w_pt_i == c);

		for (genvar b = 0; b < nn_ctrl_pkg::Z; b++)
		begin : g_bank
			// Reading does not disturb a collection, so every collection
			// that is not being written serves the read address
			assign act_addr_o[(c*nn_ctrl_pkg::Z + b)*nn_ctrl_pkg::CELL_W
				+: nn_ctrl_pkg::CELL_W] = wr_sel ? wr_cell
				: rd_addr_o[b*nn_ctrl_pkg::CELL_W +: nn_ctrl_pkg::CELL_W];

			// Bank b belongs to part b/PART_BANKS
			assign act_we_o[c*nn_ctrl_pkg::Z + b] = wr_window
				&& wr_sel
				&& (wr_part == b / nn_ctrl_pkg::PART_BANKS);
		end
	end

endmodule

// ==== common/nn_ctrl_pkg.sv ====
package nn_ctrl_pkg;

	// Network shape seen by this hidden layer

	// Fan-out per neuron, so a collection splits into this many parts
	localparam int FO = 2;

	// Neurons in this layer
	localparam int P = 16;

	// Memory banks per collection, i.e. the degree of parallelism
	localparam int Z = 4;

	localparam int L = 3; // Total number of layers
	localparam int H = 1; // Position of this layer, the one after the input layer is 1

	// Cycle timing

	// Banks of one part, written together in the same clock
	localparam int PART_BANKS = Z / FO;

	// Working clocks of one training cycle
	localparam int ACTIVE_CLKS = P / Z * FO;

	// Two spare clocks cover the latency of the memories
	localparam int CPC = ACTIVE_CLKS + 2;

	// Collections

	// Activation and sigmoid-prime collections rotate through this many sets
	// so that one is written while the others feed forward and update
	localparam int COLL = 2 * (L - H) - 1;

	// Field widths

	// Cycle index counts 0 to CPC-1
	localparam int CI_W = $clog2(CPC);

	// Each activation or delta bank holds P/Z cells
	localparam int CELL_W = $clog2(P / Z);

	// A memory index names one neuron of the layer
	// Its upper CELL_W bits are the cell, the lower bits the bank
	localparam int IDX_W = $clog2(P);

	// Selects one of COLL activation collections
	localparam int PTR_W = $clog2(COLL);

	// Each weight memory holds P*FO/Z cells, one per working clock
	localparam int WADDR_W = $clog2(P * FO / Z);

endpackage

// ==== delta_ctrl/delta_ctrl.sv ====
`timescale 1ns/1ns

module delta_ctrl
(
	input  logic                                            clk,
	input  logic                                            arst_n_i,
	input  logic [nn_ctrl_pkg::CI_W-1:0]                 cycle_index_i,
	input  logic [nn_ctrl_pkg::CI_W-1:0]                 ci_d1_i,
	input  logic                                            d_rbp_pt_i,
	input  logic [nn_ctrl_pkg::Z*nn_ctrl_pkg::CELL_W-1:0] rd_addr_i, // Interleaved cell per bank
	// Both delta collections, collection 0 in the low half
	output logic [2*nn_ctrl_pkg::Z*nn_ctrl_pkg::CELL_W-1:0] d_addr_a_o,
	output logic [2*nn_ctrl_pkg::Z-1:0]                     d_we_a_o,
	output logic [2*nn_ctrl_pkg::Z*nn_ctrl_pkg::CELL_W-1:0] d_addr_b_o,
	output logic [2*nn_ctrl_pkg::Z-1:0]                     d_we_b_o
);

	// One collection is read in order for back-propagation of the previous
	// layer while the other accumulates partial deltas by read-modify-write

	logic [nn_ctrl_pkg::CELL_W-1:0]          seq_addr; // In-order cell, part by part
	logic [nn_ctrl_pkg::CELL_W-1:0]          seq_addr_d; // Cell read last clock, cleared now
	logic [nn_ctrl_pkg::Z*nn_ctrl_pkg::CELL_W-1:0] rd_addr_d; // Cells read last clock
	logic [$clog2(nn_ctrl_pkg::FO)-1:0]      clr_part; // Part whose banks are cleared now
	logic                                    rmw_window;
	logic                                    clr_window;

	assign seq_addr = cycle_index_i[nn_ctrl_pkg::CELL_W + $clog2(nn_ctrl_pkg::FO) - 1
		-: nn_ctrl_pkg::CELL_W];

	assign clr_part = ci_d1_i[$clog2(nn_ctrl_pkg::FO)-1:0];

	// Write-back follows each read by one clock, in both collections
	always_ff @(posedge clk)
	begin
		seq_addr_d <= seq_addr;
		rd_addr_d  <= rd_addr_i;
	end

	// Accumulated values land one clock after their reads start
	assign rmw_window = arst_n_i
		&& (cycle_index_i != '0)
		&& (cycle_index_i <= nn_ctrl_pkg::ACTIVE_CLKS);

	// Clearing also trails the read by a clock, hence ci_d1 and not the raw index
	assign clr_window = arst_n_i && (ci_d1_i < nn_ctrl_pkg::CPC - 2);

	for (genvar c = 0; c < 2; c++)
	begin : g_coll
		logic rbp_sel; // This collection is read for back-propagation

		assign rbp_sel = (d_rbp_pt_i == c);

		for (genvar b = 0; b < nn_ctrl_pkg::Z; b++)
		begin : g_bank
			// Port A reads in order here, or writes the accumulated value back
			assign d_addr_a_o[(c*nn_ctrl_pkg::Z + b)*nn_ctrl_pkg::CELL_W
				+: nn_ctrl_pkg::CELL_W] = rbp_sel ? seq_addr
				: rd_addr_d[b*nn_ctrl_pkg::CELL_W +: nn_ctrl_pkg::CELL_W];

			// Port B zeroes a cell once it has been read, or feeds the accumulator
			assign d_addr_b_o[(c*nn_ctrl_pkg::Z + b)*nn_ctrl_pkg::CELL_W
				+: nn_ctrl_pkg::CELL_W] = rbp_sel ? seq_addr_d
				: rd_addr_i[b*nn_ctrl_pkg::CELL_W +: nn_ctrl_pkg::CELL_W];

			assign d_we_a_o[c*nn_ctrl_pkg::Z + b] = !rbp_sel && rmw_window;

			// The collection must be all zero before it accumulates next cycle
			assign d_we_b_o[c*nn_ctrl_pkg::Z + b] = rbp_sel
				&& clr_window
				&& (clr_part == b / nn_ctrl_pkg::PART_BANKS);
		end
	end

endmodule

// ==== dv/hidden_layer_ctrl_sva.sv ====
`timescale 1ns/1ns

module hidden_layer_ctrl_sva
(
	input logic                                       clk,
	input logic                                       arst_n_i,
	input logic [nn_ctrl_pkg::CI_W-1:0]               cycle_index_i,
	input logic [nn_ctrl_pkg::CI_W-1:0]               ci_d2_i, // Index two clocks late
	input logic [nn_ctrl_pkg::PTR_W-1:0]              w_pt_i,
	input logic [nn_ctrl_pkg::PTR_W-1:0]              rff_pt_i, // Delayed feed-forward select
	input logic [nn_ctrl_pkg::PTR_W-1:0]              rup_pt_i, // Delayed update select
	input logic [2*nn_ctrl_pkg::Z-1:0]                d_we_a_i,
	input logic [nn_ctrl_pkg::COLL*nn_ctrl_pkg::Z-1:0] act_we_i
);

	logic rmw_coll0; // Some bank of delta collection 0 takes a write-back
	logic rmw_coll1;

	assign rmw_coll0 = |d_we_a_i[nn_ctrl_pkg::Z-1:0];
	assign rmw_coll1 = |d_we_a_i[2*nn_ctrl_pkg::Z-1:nn_ctrl_pkg::Z];

	// The read selects trail the raw pointers by a clock, so they meet last clock's w_pt
	a_wpt_apart: assert property (@(posedge clk) disable iff (!arst_n_i)
		($past(w_pt_i) != rff_pt_i) && ($past(w_pt_i) != rup_pt_i))
		else $error("Write collection coincides with a read collection");

	// Read-modify-write goes to one delta collection only
	a_one_rmw: assert property (@(posedge clk) disable iff (!arst_n_i)
		((cycle_index_i != '0) && (cycle_index_i <= nn_ctrl_pkg::CI_W'(nn_ctrl_pkg::ACTIVE_CLKS)))
		|-> (rmw_coll0 ^ rmw_coll1))
		else $error("Delta port A write is not in exactly one collection");

	a_act_slack: assert property (@(posedge clk) disable iff (!arst_n_i)
		(ci_d2_i >= nn_ctrl_pkg::CI_W'(nn_ctrl_pkg::ACTIVE_CLKS)) |-> (act_we_i == '0))
		else $error("Activation write enable high in the slack clocks");

endmodule

// ==== dv/tb_hidden_layer_ctrl.sv ====
`timescale 1ns/1ns

module tb_hidden_layer_ctrl;

	localparam int N_CYCLES = 200; // Training cycles after reset
	localparam int RST_CLKS = 4; // Clocks held in reset
	localparam int RUN_CLKS = N_CYCLES * nn_ctrl_pkg::CPC;
	localparam int MI_W = nn_ctrl_pkg::Z * nn_ctrl_pkg::IDX_W;
	localparam int RD_W = nn_ctrl_pkg::Z * nn_ctrl_pkg::CELL_W;
	localparam int ACT_W = nn_ctrl_pkg::COLL * RD_W;
	localparam time WATCHDOG_NS = 2 * RUN_CLKS * 8;

	logic clk, arst_n_i, cycle_clk_i;
	logic [nn_ctrl_pkg::CI_W-1:0] cycle_index_i;
	logic [MI_W-1:0] mem_index_i;
	logic w_we_o, d_rbp_pt_o;
	logic [nn_ctrl_pkg::WADDR_W-1:0] w_raddr_o, w_waddr_o;
	logic [nn_ctrl_pkg::PTR_W-1:0] rff_pt_o, rup_pt_o;
	logic [ACT_W-1:0] act_addr_o;
	logic [nn_ctrl_pkg::COLL*nn_ctrl_pkg::Z-1:0] act_we_o;
	logic [2*RD_W-1:0] d_addr_a_o, d_addr_b_o;
	logic [2*nn_ctrl_pkg::Z-1:0] d_we_a_o, d_we_b_o;

	integer seed;
	logic started, arst_q; // arst_q is reset as seen one clock earlier
	logic [nn_ctrl_pkg::CI_W-1:0] ci_d1_m, ci_d2_m;
	logic [nn_ctrl_pkg::PTR_W-1:0] rff_m, w_m, rup_m, rff_d_m, rup_d_m;
	logic rbp_m;
	logic [nn_ctrl_pkg::WADDR_W-1:0] w_waddr_m;
	logic [nn_ctrl_pkg::CELL_W-1:0] seq_d_m; // In-order delta cell of last clock
	logic [RD_W-1:0] rd_d_m; // Interleaved cells of last clock

	hidden_layer_ctrl dut0 (.*);

	bind hidden_layer_ctrl hidden_layer_ctrl_sva sva0
	(
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.cycle_index_i (cycle_index_i),
		.ci_d2_i       (ci_d2),
		.w_pt_i        (w_pt),
		.rff_pt_i      (rff_pt_o),
		.rup_pt_i      (rup_pt_o),
		.d_we_a_i      (d_we_a_o),
		.act_we_i      (act_we_o)
	);

	function automatic logic [nn_ctrl_pkg::PTR_W-1:0] next_collection(
		input logic [nn_ctrl_pkg::PTR_W-1:0] pt
	);
		return nn_ctrl_pkg::PTR_W'((int'(pt) + 1) % nn_ctrl_pkg::COLL);
	endfunction

	// Cell visited at a given count, since each cell is shared by FO parts
	function automatic logic [nn_ctrl_pkg::CELL_W-1:0] cell_of_count(
		input logic [nn_ctrl_pkg::CI_W-1:0] ci
	);
		return nn_ctrl_pkg::CELL_W'(int'(ci) / nn_ctrl_pkg::FO);
	endfunction

	// Upper CELL_W bits of every memory index
	function automatic logic [RD_W-1:0] cells_of(input logic [MI_W-1:0] mi);
		logic [RD_W-1:0] cells;
		for (int b = 0; b < nn_ctrl_pkg::Z; b++)
			cells[b*nn_ctrl_pkg::CELL_W +: nn_ctrl_pkg::CELL_W] = nn_ctrl_pkg::CELL_W'(
				mi[b*nn_ctrl_pkg::IDX_W +: nn_ctrl_pkg::IDX_W]
				>> (nn_ctrl_pkg::IDX_W - nn_ctrl_pkg::CELL_W));
		return cells;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("** FAIL **");
			$fatal(1, "Output %s does not match the reference model", what);
		end
	endtask

	task automatic compare_outputs();
		logic [ACT_W-1:0] act_addr_e;
		logic [nn_ctrl_pkg::COLL*nn_ctrl_pkg::Z-1:0] act_we_e;
		logic [2*RD_W-1:0] d_addr_a_e, d_addr_b_e;
		logic [2*nn_ctrl_pkg::Z-1:0] d_we_a_e, d_we_b_e;
		logic [RD_W-1:0] rd;
		int ci, c1, c2;
		rd = cells_of(mem_index_i);
		ci = int'(cycle_index_i);
		c1 = int'(ci_d1_m);
		c2 = int'(ci_d2_m);
		for (int c = 0; c < nn_ctrl_pkg::COLL; c++)
			for (int b = 0; b < nn_ctrl_pkg::Z; b++)
			begin
				act_addr_e[(c*nn_ctrl_pkg::Z+b)*nn_ctrl_pkg::CELL_W +: nn_ctrl_pkg::CELL_W] =
					(c == int'(w_m)) ? cell_of_count(ci_d2_m)
					: rd[b*nn_ctrl_pkg::CELL_W +: nn_ctrl_pkg::CELL_W];
				act_we_e[c*nn_ctrl_pkg::Z+b] = arst_n_i && (c == int'(w_m))
					&& (c2 < nn_ctrl_pkg::ACTIVE_CLKS)
					&& (b / nn_ctrl_pkg::PART_BANKS == c2 % nn_ctrl_pkg::FO);
			end
		for (int c = 0; c < 2; c++)
			for (int b = 0; b < nn_ctrl_pkg::Z; b++)
			begin
				d_addr_a_e[(c*nn_ctrl_pkg::Z+b)*nn_ctrl_pkg::CELL_W +: nn_ctrl_pkg::CELL_W] =
					(c == int'(rbp_m)) ? cell_of_count(cycle_index_i)
					: rd_d_m[b*nn_ctrl_pkg::CELL_W +: nn_ctrl_pkg::CELL_W];
				d_addr_b_e[(c*nn_ctrl_pkg::Z+b)*nn_ctrl_pkg::CELL_W +: nn_ctrl_pkg::CELL_W] =
					(c == int'(rbp_m)) ? seq_d_m
					: rd[b*nn_ctrl_pkg::CELL_W +: nn_ctrl_pkg::CELL_W];
				d_we_a_e[c*nn_ctrl_pkg::Z+b] = arst_n_i && (c != int'(rbp_m))
					&& (ci != 0) && (ci <= nn_ctrl_pkg::ACTIVE_CLKS);
				d_we_b_e[c*nn_ctrl_pkg::Z+b] = arst_n_i && (c == int'(rbp_m))
					&& (c1 < nn_ctrl_pkg::CPC - 2)
					&& (b / nn_ctrl_pkg::PART_BANKS == c1 % nn_ctrl_pkg::FO);
			end
		check_value("w_we_o", 32'(w_we_o),
			32'(arst_n_i && (ci != 0) && (ci <= nn_ctrl_pkg::CPC - 2)));
		check_value("w_raddr_o", 32'(w_raddr_o), 32'(ci % (1 << nn_ctrl_pkg::WADDR_W)));
		check_value("w_waddr_o", 32'(w_waddr_o), 32'(w_waddr_m));
		check_value("rff_pt_o", 32'(rff_pt_o), 32'(rff_d_m));
		check_value("rup_pt_o", 32'(rup_pt_o), 32'(rup_d_m));
		check_value("d_rbp_pt_o", 32'(d_rbp_pt_o), 32'(rbp_m));
		check_value("act_addr_o", 32'(act_addr_o), 32'(act_addr_e));
		check_value("act_we_o", 32'(act_we_o), 32'(act_we_e));
		check_value("d_addr_a_o", 32'(d_addr_a_o), 32'(d_addr_a_e));
		check_value("d_addr_b_o", 32'(d_addr_b_o), 32'(d_addr_b_e));
		check_value("d_we_a_o", 32'(d_we_a_o), 32'(d_we_a_e));
		check_value("d_we_b_o", 32'(d_we_b_o), 32'(d_we_b_e));
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// Reference model, registers mirror the DUT state at each rising edge
	always @(posedge clk)
	begin
		started   <= 1'b1;
		arst_q    <= arst_n_i;
		w_waddr_m <= nn_ctrl_pkg::WADDR_W'(int'(cycle_index_i) % (1 << nn_ctrl_pkg::WADDR_W));
		seq_d_m   <= cell_of_count(cycle_index_i);
		rd_d_m    <= cells_of(mem_index_i);
		if (!arst_n_i)
		begin
			ci_d1_m <= nn_ctrl_pkg::CI_W'(nn_ctrl_pkg::CPC - 1);
			ci_d2_m <= nn_ctrl_pkg::CI_W'(nn_ctrl_pkg::CPC - 1);
			{rff_m, w_m, rup_m, rbp_m} <= {2'd0, 2'd1, 2'd2, 1'b0};
			{rff_d_m, rup_d_m} <= {2'd0, 2'd2};
		end
		else
		begin
			ci_d1_m <= cycle_index_i;
			ci_d2_m <= ci_d1_m;
			rff_d_m <= rff_m; // Memories answer a clock later
			rup_d_m <= rup_m;
			if (cycle_clk_i)
			begin
				rff_m <= next_collection(rff_m);
				w_m   <= next_collection(w_m);
				rup_m <= next_collection(rup_m);
				rbp_m <= ~rbp_m;
			end
		end
	end

	// Outputs are settled by the falling edge
	always @(negedge clk)
	begin
		if (started)
		begin
			if (!arst_n_i || !arst_q)
				check_value("write enables around reset", 32'({w_we_o, act_we_o, d_we_a_o,
					d_we_b_o}), 32'd0);
			compare_outputs();
		end
	end

	initial
	begin
		seed = 32'he611_1593;
		started = 1'b0;
		arst_n_i = 1'b0;
		// The index already runs in reset, so the gating of the enables is exercised,
		// and it wraps to 0 in the clock where reset is released
		cycle_index_i = nn_ctrl_pkg::CI_W'(nn_ctrl_pkg::CPC - RST_CLKS);
		cycle_clk_i = 1'b0;
		mem_index_i = '0;
		for (int n = 1; n < RST_CLKS + RUN_CLKS; n++)
		begin
			@(posedge clk);
			if (n == RST_CLKS)
				arst_n_i <= 1'b1;
			cycle_index_i <= nn_ctrl_pkg::CI_W'((n + nn_ctrl_pkg::CPC - RST_CLKS)
				% nn_ctrl_pkg::CPC);
			cycle_clk_i   <= ((n + nn_ctrl_pkg::CPC - RST_CLKS) % nn_ctrl_pkg::CPC == 0);
			mem_index_i   <= MI_W'($random(seed));
		end
		repeat (2) @(posedge clk); // Last values are checked on the falling edge between
		$display("** PASS **");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Simulation did not finish within %0t ns", WATCHDOG_NS);
		$display("** FAIL **");
		$fatal(1, "Watchdog expired");
	end

endmodule

// ==== hidden_layer_ctrl.f ====
common/nn_ctrl_pkg.sv
logic/cycle_timing.sv
logic/collection_pointers.sv
act_ctrl/act_sp_ctrl.sv
delta_ctrl/delta_ctrl.sv
logic/hidden_layer_ctrl.sv
dv/hidden_layer_ctrl_sva.sv
dv/tb_hidden_layer_ctrl.sv

// ==== logic/collection_pointers.sv ====
`timescale 1ns/1ns

module collection_pointers
(
	input  logic                             clk,
	input  logic                             arst_n_i,
	input  logic                             cycle_clk_i, // One clock wide, at index 0
	output logic [nn_ctrl_pkg::PTR_W-1:0] w_pt_o, // Collection being written by feed-forward
	output logic [nn_ctrl_pkg::PTR_W-1:0] rff_pt_o, // Feed-forward read, one clock late
	output logic [nn_ctrl_pkg::PTR_W-1:0] rup_pt_o, // Update read, one clock late
	output logic                             d_rbp_pt_o // Delta collection read for back-propagation
);

	logic [nn_ctrl_pkg::PTR_W-1:0] rff_pt; // Raw feed-forward read pointer
	logic [nn_ctrl_pkg::PTR_W-1:0] rup_pt; // Raw update read pointer, also the sigmoid-prime source

	// Next collection in the rotation, wrapping after the last one
	function automatic logic [nn_ctrl_pkg::PTR_W-1:0] ptr_next(
		input logic [nn_ctrl_pkg::PTR_W-1:0] pt
	);
		if (pt == nn_ctrl_pkg::COLL - 1)
			return '0;
		return pt + 1'b1;
	endfunction

	// Pointers start one collection apart and keep that spacing
	// so w_pt never lands on a collection that is being read
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			rff_pt     <= '0;
			w_pt_o     <= nn_ctrl_pkg::PTR_W'(1); // Always the collection after rff
			rup_pt     <= nn_ctrl_pkg::PTR_W'(2); // Always two after rff
			d_rbp_pt_o <= 1'b0;
		end
		else if (cycle_clk_i)
		begin
			rff_pt     <= ptr_next(rff_pt);
			w_pt_o     <= ptr_next(w_pt_o);
			rup_pt     <= ptr_next(rup_pt);
			d_rbp_pt_o <= ~d_rbp_pt_o; // Only two delta collections, so it just toggles
		end
	end

	// The memories answer one clock after the address, so the read
	// selects that follow them must lag by one clock as well
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			rff_pt_o <= '0;
			rup_pt_o <= nn_ctrl_pkg::PTR_W'(2);
		end
		else
		begin
			rff_pt_o <= rff_pt;
			rup_pt_o <= rup_pt;
		end
	end

endmodule

// ==== logic/cycle_timing.sv ====
`timescale 1ns/1ns

module cycle_timing
(
	input  logic                               clk,
	input  logic                               arst_n_i,
	input  logic [nn_ctrl_pkg::CI_W-1:0]    cycle_index_i, // Runs 0 to CPC-1 and wraps
	output logic [nn_ctrl_pkg::CI_W-1:0]    ci_d1_o, // Index one clock late, for delta clearing
	output logic [nn_ctrl_pkg::CI_W-1:0]    ci_d2_o, // Index two clocks late, for activation writes
	output logic                               w_we_o,
	output logic [nn_ctrl_pkg::WADDR_W-1:0] w_raddr_o,
	output logic [nn_ctrl_pkg::WADDR_W-1:0] w_waddr_o
);

	// Two-stage delay line of the cycle index
	// Both stages come out of reset at the last index of a cycle
	// Then no write window opens before the first real cycle arrives
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			ci_d1_o <= nn_ctrl_pkg::CI_W'(nn_ctrl_pkg::CPC - 1);
			ci_d2_o <= nn_ctrl_pkg::CI_W'(nn_ctrl_pkg::CPC - 1);
		end
		else
		begin
			ci_d1_o <= cycle_index_i;
			ci_d2_o <= ci_d1_o; // Second stage follows the first
		end
	end

	// Every weight memory reads the same cell in a given clock
	// The top bit of the index only accounts for the two spare clocks
	assign w_raddr_o = cycle_index_i[nn_ctrl_pkg::WADDR_W-1:0];

	// The cell read now is written back one clock later
	always_ff @(posedge clk)
	begin
		w_waddr_o <= w_raddr_o;
	end

	// Write-back runs from index 1 through CPC-2, one clock behind the reads
	assign w_we_o = arst_n_i
		&& (cycle_index_i != '0)
		&& (cycle_index_i <= nn_ctrl_pkg::CPC - 2);

endmodule

// ==== logic/hidden_layer_ctrl.sv ====
`timescale 1ns/1ns

module hidden_layer_ctrl
(
	input  logic                                            clk,
	input  logic                                            arst_n_i,
	input  logic [nn_ctrl_pkg::CI_W-1:0]                 cycle_index_i,
	input  logic                                            cycle_clk_i,
	input  logic [nn_ctrl_pkg::Z*nn_ctrl_pkg::IDX_W-1:0] mem_index_i,
	// Weight memories
	output logic                                            w_we_o,
	output logic [nn_ctrl_pkg::WADDR_W-1:0]              w_raddr_o,
	output logic [nn_ctrl_pkg::WADDR_W-1:0]              w_waddr_o,
	// Collection selects for the read data paths
	output logic [nn_ctrl_pkg::PTR_W-1:0]                rff_pt_o,
	output logic [nn_ctrl_pkg::PTR_W-1:0]                rup_pt_o,
	output logic                                            d_rbp_pt_o,
	// Activation and sigmoid-prime memories
	output logic [nn_ctrl_pkg::COLL*nn_ctrl_pkg::Z*nn_ctrl_pkg::CELL_W-1:0] act_addr_o,
	output logic [nn_ctrl_pkg::COLL*nn_ctrl_pkg::Z-1:0]                     act_we_o,
	// Delta memories
	output logic [2*nn_ctrl_pkg::Z*nn_ctrl_pkg::CELL_W-1:0] d_addr_a_o,
	output logic [2*nn_ctrl_pkg::Z-1:0]                     d_we_a_o,
	output logic [2*nn_ctrl_pkg::Z*nn_ctrl_pkg::CELL_W-1:0] d_addr_b_o,
	output logic [2*nn_ctrl_pkg::Z-1:0]                     d_we_b_o
);

	logic [nn_ctrl_pkg::CI_W-1:0]                  ci_d1; // Index one clock late
	logic [nn_ctrl_pkg::CI_W-1:0]                  ci_d2; // Index two clocks late
	logic [nn_ctrl_pkg::PTR_W-1:0]                 w_pt; // Activation collection being filled
	logic [nn_ctrl_pkg::Z*nn_ctrl_pkg::CELL_W-1:0] rd_addr; // Cell fields of the memory indices

	cycle_timing u_cycle_timing
	(
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.cycle_index_i (cycle_index_i),
		.ci_d1_o       (ci_d1),
		.ci_d2_o       (ci_d2),
		.w_we_o        (w_we_o),
		.w_raddr_o     (w_raddr_o),
		.w_waddr_o     (w_waddr_o)
	);

	// Rotation of all collections, advanced once per training cycle
	collection_pointers u_collection_pointers
	(
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.cycle_clk_i (cycle_clk_i),
		.w_pt_o      (w_pt),
		.rff_pt_o    (rff_pt_o),
		.rup_pt_o    (rup_pt_o),
		.d_rbp_pt_o  (d_rbp_pt_o)
	);

	act_sp_ctrl u_act_sp_ctrl
	(
		.arst_n_i    (arst_n_i),
		.ci_d2_i     (ci_d2),
		.w_pt_i      (w_pt),
		.mem_index_i (mem_index_i),
		.act_addr_o  (act_addr_o),
		.act_we_o    (act_we_o),
		.rd_addr_o   (rd_addr)
	);

	// Delta reads use the same interleaved cells as the activation reads
	delta_ctrl u_delta_ctrl
	(
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.cycle_index_i (cycle_index_i),
		.ci_d1_i       (ci_d1),
		.d_rbp_pt_i    (d_rbp_pt_o),
		.rd_addr_i     (rd_addr),
		.d_addr_a_o    (d_addr_a_o),
		.d_we_a_o      (d_we_a_o),
		.d_addr_b_o    (d_addr_b_o),
		.d_we_b_o      (d_we_b_o)
	);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the hidden-layer control testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_hidden_layer_ctrl \
	-f hidden_layer_ctrl.f -o sim_hidden_layer_ctrl
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_hidden_layer_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1
